/* run.sh */
#!/bin/sh
# Build the mesh router testbench with Verilator, run it, then look for the fail message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_mesh_router -o tb_mesh_router \
   > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/tb_mesh_router > sim.log 2>&1 || { cat sim.log; echo "Simulation did not finish"; exit 1; }

cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0

/* sim.f */
source/noc_addr_pkg.sv
source/noc_flit_pkg.sv
source/output_stage.sv
source/route_unit.sv
source/mesh_router.sv
test/tb_mesh_router.sv

/* source/mesh_router.sv */
`timescale 1ns/100ps
`default_nettype none

module mesh_router (
   input  wire                                                    reset,     // Clock
   input  wire                                                    clk,       // Async reset
   input  wire noc_addr_pkg::node_addr_t                          node_addr,
   input  wire                                                    in_valid,
   input  wire noc_flit_pkg::flit_t                               in_flit,
   output logic                                                   in_ready,
   output logic [noc_addr_pkg::NUM_DIRS-1:0]                      out_valid,
   output noc_flit_pkg::flit_t [noc_addr_pkg::NUM_DIRS-1:0]       out_flit,
   input  wire  [noc_addr_pkg::NUM_DIRS-1:0]                      out_ready
);

   // ------------------------------
   // Route unit to stages
   // ------------------------------

   logic [noc_addr_pkg::NUM_DIRS-1:0] stage_valid;   // One-hot while in_valid
   logic [noc_addr_pkg::NUM_DIRS-1:0] stage_ready;
   noc_flit_pkg::flit_t               stage_flit;    // Shared by all stages

   route_unit route_unit_inst (
      .reset       (reset),
      .clk         (clk),
      .node_addr   (node_addr),
      .in_valid    (in_valid),
      .in_flit     (in_flit),
      .in_ready    (in_ready),
      .stage_valid (stage_valid),
      .stage_flit  (stage_flit),
      .stage_ready (stage_ready)
   );

   // ------------------------------
   // Output stages
   // ------------------------------

   // Index d follows the dir_e code, north at 0 and local at 4
   for (genvar d = 0; d < noc_addr_pkg::NUM_DIRS; d++) begin : g_dir
      output_stage output_stage_inst (
         .reset     (reset),
         .clk       (clk),
         .in_valid  (stage_valid[d]),
         .in_flit   (stage_flit),
         .in_ready  (stage_ready[d]),
         .out_valid (out_valid[d]),
         .out_flit  (out_flit[d]),
         .out_ready (out_ready[d])
      );
   end

endmodule

`default_nettype wire

/* source/noc_addr_pkg.sv */
`default_nettype none

package noc_addr_pkg;

   // ------------------------------
   // Mesh geometry
   // ------------------------------

   localparam int COORD_W = 8;   // Bits per coordinate
   localparam int DIR_W   = 3;   // Bits per direction code

   // Output directions of one tile
   localparam int NUM_DIRS = 5;

   // One position along an axis
   typedef logic [COORD_W-1:0] coord_t;

   // Tile address, y in the upper byte
   typedef struct packed {
      coord_t y;
      coord_t x;
   } node_addr_t;

   // ------------------------------
   // Direction codes
   // ------------------------------

   // North is increasing y, east is increasing x
   typedef enum logic [DIR_W-1:0] {
      dir_north = 3'd0,
      dir_east  = 3'd1,
      dir_south = 3'd2,
      dir_west  = 3'd3,
      dir_local = 3'd4   // Delivered to this tile
   } dir_e;

endpackage

`default_nettype wire

/* source/noc_flit_pkg.sv */
`default_nettype none

package noc_flit_pkg;

   // ------------------------------
   // Flit format
   // ------------------------------

   localparam int WORD_W = 16;   // Data word of one flit

   // The data word has two readings:
   //   head flit  -> destination tile address
   //   other flit -> plain payload
   typedef union packed {
      logic [WORD_W-1:0]        payload;
      noc_addr_pkg::node_addr_t dest;
   } flit_word_u;

   // ------------------------------
   // Flit with packet markers
   // ------------------------------

   // Word on top, markers in the low two bits
   typedef struct packed {
      flit_word_u word;
      logic       sop;   // First flit of a packet
      logic       eop;   // Last flit of a packet
   } flit_t;

   // A packet of one flit has both sop and eop set.
   // The route is then decided and released on that single beat.

endpackage

`default_nettype wire

/* source/output_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module output_stage (
   input  wire                       reset,       // Clock
   input  wire                       clk,         // Async reset, active high
   input  wire                       in_valid,
   input  wire noc_flit_pkg::flit_t  in_flit,
   output logic                      in_ready,
   output logic                      out_valid,
   output noc_flit_pkg::flit_t       out_flit,
   input  wire                       out_ready
);

   logic load;   // Flit enters the register

   // ------------------------------
   // Handshake
   // ------------------------------

   // Free when empty, or when the held flit leaves this cycle
   assign in_ready = out_ready || !out_valid;

   assign load = in_valid && in_ready;

   // ------------------------------
   // Register
   // ------------------------------

   // Full after an accepted flit, empty once it drains with nothing behind it
   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         out_valid <= 1'b0;
      end else if (load) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   // Flit held steady while the sink stalls
   always_ff @(posedge reset) begin
      if (load) begin
         out_flit <= in_flit;
      end
   end

endmodule

`default_nettype wire

/* source/route_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module route_unit (
   input  wire                                reset,        // Clock
   input  wire                                clk,          // Async reset, active high
   input  wire noc_addr_pkg::node_addr_t      node_addr,    // Own tile coordinates
   input  wire                                in_valid,
   input  wire noc_flit_pkg::flit_t           in_flit,
   output logic                               in_ready,
   output logic [noc_addr_pkg::NUM_DIRS-1:0]  stage_valid,
   output noc_flit_pkg::flit_t                stage_flit,
   input  wire  [noc_addr_pkg::NUM_DIRS-1:0]  stage_ready
);

   // ------------------------------
   // Declarations
   // ------------------------------

   noc_addr_pkg::node_addr_t dest;        // Head word seen as an address
   noc_addr_pkg::dir_e       head_dir;    // Direction the head asks for
   noc_addr_pkg::dir_e       held_dir;    // Direction locked for the packet
   noc_addr_pkg::dir_e       cur_dir;     // Direction used this cycle

   logic y_gt;
   logic y_lt;
   logic x_gt;
   logic x_lt;
   logic at_node;

   logic pkt_active;   // Packet in progress, body flits follow held_dir
   logic xfer;         // Flit accepted this cycle
   logic head_xfer;
   logic tail_xfer;

   // ------------------------------
   // Route decision
   // ------------------------------

   // Only meaningful while the flit is a head
   assign dest = in_flit.word.dest;

   assign y_gt    = dest.y > node_addr.y;
   assign y_lt    = dest.y < node_addr.y;
   assign x_gt    = dest.x > node_addr.x;
   assign x_lt    = dest.x < node_addr.x;
   assign at_node = !y_gt && !y_lt && !x_gt && !x_lt;

   // Dimension order, y first, first match wins
   always_comb begin
      if (at_node) begin
         head_dir = noc_addr_pkg::dir_local;
      end else if (y_gt) begin
         head_dir = noc_addr_pkg::dir_north;
      end else if (x_gt) begin
         head_dir = noc_addr_pkg::dir_east;
      end else if (y_lt) begin
         head_dir = noc_addr_pkg::dir_south;
      end else begin
         // Same row and not east, so x is smaller
         head_dir = noc_addr_pkg::dir_west;
      end
   end

   // Body flits never look at their word, they keep the locked route
   assign cur_dir = pkt_active ? held_dir : head_dir;

   // ------------------------------
   // Steering
   // ------------------------------

   // One-hot valid towards the chosen stage
   always_comb begin
      stage_valid          = '0;
      stage_valid[cur_dir] = in_valid;
   end

   // Only the chosen stage can hold the input back
   assign in_ready = stage_ready[cur_dir];

   assign stage_flit = in_flit;   // Passed on unchanged

   // ------------------------------
   // Direction lock
   // ------------------------------

   assign xfer      = in_valid && in_ready;
   assign head_xfer = xfer && in_flit.sop && !pkt_active;
   assign tail_xfer = xfer && in_flit.eop;

   // Set by a head, cleared by the eop beat.
   // A single-flit packet hits both and ends up clear.
   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         pkt_active <= 1'b0;
      end else if (tail_xfer) begin
         pkt_active <= 1'b0;
      end else if (head_xfer) begin
         pkt_active <= 1'b1;
      end
   end

   // Route of the packet now being forwarded
   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         held_dir <= noc_addr_pkg::dir_local;
      end else if (head_xfer) begin
         held_dir <= head_dir;
      end
   end

endmodule

`default_nettype wire

/* test/router_vectors.txt */
# Mesh router vectors, one command per line, lines starting with # are comments
#   N node                 own node address, hex yyxx
#   M gaps stalls          1 turns on random input gaps, 1 turns on random out_ready stalls
#   P dest len seed dir    packet to dest (hex yyxx) of len flits, body words are seed
#                          (hex) with a random low nibble, expected dir
#                          0 north, 1 east, 2 south, 3 west, 4 local

# Node (3,3), every quadrant, both axes and the node itself
N 0303
M 0 0
P 0303 1 0000 4
P 0505 3 0101 0
P 0105 3 0303 1
P 0501 2 0006 0
P 0101 4 0903 2
P 0306 2 0300 1
P 0300 3 0306 3
P 0603 1 0000 0
P 0003 2 0330 2

# Single-flit packets, a new direction every time
P 0306 1 0000 1
P 0300 1 0000 3
P 0303 1 0000 4
P 0603 1 0000 0

# Node (0x10,0x20)
N 1020
M 0 0
P 1020 2 2030 4
P 2030 3 0510 0
P 0530 2 2010 1
P 2010 4 1020 0
P 0510 3 1021 2
P 1021 2 101f 1
P 101f 3 1120 3
P 1120 1 0000 0
P 0f20 2 1021 2

# Corner nodes
N ffff
P 0000 2 ffff 2
P ff00 2 0000 3
P ffff 1 0000 4
N 0000
P 00ff 2 ff00 1
P ff00 2 00ff 0
P 0000 2 ffff 4

# Random gaps and random stalls on every output
N 0303
M 1 1
P 0909 6 0101 0
P 0108 5 0303 1
P 0000 7 0909 2
P 0301 4 0308 3
P 0303 5 0000 4
P 0808 8 0000 0
P 0207 3 0303 1
P 0203 6 0903 2
P 0302 4 0306 3
N 1020
P 0020 5 1020 2
P 10f0 4 1000 1
P 1000 6 10f0 3
P ff20 3 0020 0

# Back-to-back packets, stalls only
N 0303
M 0 1
P 0505 4 0000 0
P 0106 4 0000 1
P 0002 4 0000 2
P 0301 4 0000 3
P 0303 4 0000 4
P 0707 3 0000 0
P 0309 3 0000 1

# Back-to-back packets, no gaps and no stalls
M 0 0
P 0404 3 0202 0
P 0204 3 0404 1
P 0101 3 0505 2
P 0302 3 0304 3
P 0303 2 0101 4

/* test/tb_mesh_router.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mesh_router;

   localparam int    NUM_DIRS = noc_addr_pkg::NUM_DIRS;
   localparam int    TIMEOUT  = 200;   // Cycles allowed for any one wait
   localparam string VEC_FILE = "test/router_vectors.txt";

   // One flit of the stream and the setup it is sent under
   typedef struct packed {
      noc_addr_pkg::node_addr_t node;
      noc_flit_pkg::flit_t      flit;
      logic [2:0]               dir;      // Expected output direction
      logic                     gaps;     // Random idle cycles on the input
      logic                     stalls;   // Random low cycles on out_ready
   } stim_t;

   logic                                     reset;   // Clock
   logic                                     clk;     // Reset
   noc_addr_pkg::node_addr_t                 node_addr;
   logic                                     in_valid;
   noc_flit_pkg::flit_t                      in_flit;
   logic                                     in_ready;
   logic [NUM_DIRS-1:0]                      out_valid;
   noc_flit_pkg::flit_t [NUM_DIRS-1:0]       out_flit;
   logic [NUM_DIRS-1:0]                      out_ready;

   stim_t               stim_q [$];
   noc_flit_pkg::flit_t exp_q [NUM_DIRS][$];   // Scoreboard per direction
   logic [NUM_DIRS-1:0] stage_full;            // Modeled occupancy of each output stage
   logic [31:0]         lfsr;
   int                  mismatches;
   int                  failures;

   mesh_router mesh_router_inst (
      .reset     (reset),
      .clk       (clk),
      .node_addr (node_addr),
      .in_valid  (in_valid),
      .in_flit   (in_flit),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_flit  (out_flit),
      .out_ready (out_ready)
   );

   always #50 reset = ~reset;   // 100 ns period

   // ------------------------------
   // Helpers
   // ------------------------------

   // One step of the Galois LFSR
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'hA300_0000;
      end
      return s >> 1;
   endfunction

   // Next n random bits with one step per bit
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         bits = {bits[14:0], lfsr[0]};
      end
      return bits;
   endfunction

   // Dimension order routing where the first match wins
   function automatic logic [2:0] route_by_rule(input noc_addr_pkg::node_addr_t node,
                                                input noc_addr_pkg::node_addr_t dest);
      if (dest == node) return noc_addr_pkg::dir_local;
      if (dest.y > node.y) return noc_addr_pkg::dir_north;
      if (dest.x > node.x) return noc_addr_pkg::dir_east;
      if (dest.y < node.y) return noc_addr_pkg::dir_south;
      return noc_addr_pkg::dir_west;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
         mismatches++;
      end
   endtask

   task automatic report_fault(input string msg);
      $display("Error: %s", msg);
      failures++;
   endtask

   function automatic int flits_pending();
      int n;
      n = 0;
      for (int d = 0; d < NUM_DIRS; d++) begin
         n += exp_q[d].size();
      end
      return n;
   endfunction

   // Occupancy after the coming rising edge
   task automatic update_stages(input int load_dir);
      for (int d = 0; d < NUM_DIRS; d++) begin
         if (d == load_dir) begin
            stage_full[d] = 1'b1;
         end else if (out_ready[d]) begin
            stage_full[d] = 1'b0;
         end
      end
   endtask

   // ------------------------------
   // Vector file
   // ------------------------------

   task automatic load_vectors;
      int          fd;
      string       line;
      logic [15:0] node;
      logic [15:0] dest;
      logic [15:0] seed;
      int          len;
      int          dir;
      int          gaps;
      int          stalls;
      stim_t       s;
      fd = $fopen(VEC_FILE, "r");
      if (fd == 0) begin
         report_fault("the vector file could not be opened");
         return;
      end
      node = '0;
      gaps = 0;
      stalls = 0;
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line.substr(0, 0) == "#") continue;   // Blank or comment
         if (line.substr(0, 0) == "N") begin
            void'($sscanf(line, "N %h", node));
         end else if (line.substr(0, 0) == "M") begin
            void'($sscanf(line, "M %d %d", gaps, stalls));
         end else if (line.substr(0, 0) == "P") begin
            void'($sscanf(line, "P %h %d %h %d", dest, len, seed, dir));
            check_value($sformatf("route of %h at node %h", dest, node),
                        32'(route_by_rule(node, dest)), 32'(dir));
            for (int i = 0; i < len; i++) begin
               s.node = node;
               // Body words look like addresses with a random low nibble
               s.flit.word.payload = (i == 0) ? dest : seed ^ rand_bits(4);
               s.flit.sop = (i == 0);
               s.flit.eop = (i == len - 1);
               s.dir = 3'(dir);
               s.gaps = (gaps != 0);
               s.stalls = (stalls != 0);
               stim_q.push_back(s);
            end
         end else begin
            report_fault({"the vector file has an unknown line: ", line});
         end
      end
      $fclose(fd);
   endtask

   // ------------------------------
   // Stream driver and monitor
   // ------------------------------

   task automatic set_back_pressure(input logic on);
      for (int d = 0; d < NUM_DIRS; d++) begin
         out_ready[d] = on ? (rand_bits(2) != 16'd0) : 1'b1;   // Low about 1 in 4
      end
   endtask

   // Flits that leave the DUT at the coming rising edge
   task automatic check_outputs;
      noc_flit_pkg::flit_t want;
      check_value("out_valid", 32'(stage_full), 32'(out_valid));
      for (int d = 0; d < NUM_DIRS; d++) begin
         if (out_valid[d] && out_ready[d]) begin
            if (exp_q[d].size() == 0) begin
               report_fault($sformatf("flit %h came out on direction %0d, none was expected",
                                      out_flit[d], d));
            end else begin
               want = exp_q[d].pop_front();
               check_value($sformatf("flit on direction %0d", d), 32'(want), 32'(out_flit[d]));
            end
         end
      end
   endtask

   task automatic replay_stream;
      int    idx;
      int    stuck;      // Cycles the current flit has waited for in_ready
      int    load_dir;   // Stage loaded at the coming edge or -1
      logic  accepted;
      stim_t s;
      idx = 0;
      stuck = 0;
      accepted = 1'b0;
      while (idx < stim_q.size()) begin
         @(negedge reset);
         if (accepted) begin
            idx++;
            stuck = 0;
            in_valid = 1'b0;
         end
         accepted = 1'b0;
         if (idx < stim_q.size()) begin
            s = stim_q[idx];
            set_back_pressure(s.stalls);
            if (!in_valid && !(s.gaps && rand_bits(2) == 16'd0)) begin
               node_addr = s.node;
               in_flit = s.flit;
               in_valid = 1'b1;
            end
         end
         #1;   // Let in_ready settle
         check_outputs();
         load_dir = -1;
         if (in_valid) begin
            // Only the flit's own stage may hold the input back
            check_value("in_ready", 32'(!stage_full[s.dir] || out_ready[s.dir]), 32'(in_ready));
            if (in_ready) begin
               exp_q[s.dir].push_back(s.flit);
               accepted = 1'b1;
               load_dir = int'(s.dir);
            end else begin
               stuck++;
               if (stuck > TIMEOUT) begin
                  report_fault($sformatf("flit %0d was never accepted at the input", idx));
                  return;
               end
            end
         end
         update_stages(load_dir);
      end
   endtask

   task automatic drain_outputs;
      int waited;
      waited = 0;
      while (flits_pending() != 0 && waited < TIMEOUT) begin
         @(negedge reset);
         out_ready = '1;
         #1;
         check_outputs();
         update_stages(-1);
         waited++;
      end
      for (int d = 0; d < NUM_DIRS; d++) begin
         if (exp_q[d].size() != 0) begin
            report_fault($sformatf("no flit arrived on direction %0d, %0d still expected",
                                   d, exp_q[d].size()));
         end
      end
      @(negedge reset);
      #1;
      check_value("out_valid after drain", 32'd0, 32'(out_valid));   // Nothing duplicated
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------

   initial begin
      reset = 1'b0;
      clk = 1'b1;
      node_addr = '0;
      in_valid = 1'b0;
      in_flit = '0;
      out_ready = '1;
      stage_full = '0;
      lfsr = 32'h3713_521e;
      mismatches = 0;
      failures = 0;
      load_vectors();
      repeat (5) @(negedge reset);
      clk = 1'b0;
      #1;
      check_value("out_valid after reset", 32'd0, 32'(out_valid));
      check_value("in_ready after reset", 32'd1, 32'(in_ready));
      replay_stream();
      drain_outputs();
      $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire
